//--- Makefile
# Verilator build and run for the controller front end testbench

VERILATOR ?= verilator
TOP       ?= tb_neptuno_joy
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/board_pkg.sv
/* Board-side definitions: serial chain layout, scanner states and front button indices.
   Referenced by scoped name from the scanner and the merge stage. */
`default_nettype none

package board_pkg;

    // length of the external shift register chain
    localparam int CHAIN_BITS = 16;
    // lowest chain bit of each pad field
    localparam int PAD1_LSB = 0;
    localparam int PAD2_LSB = 8;

    // serial chain scanner states
    typedef enum logic [2:0] {
        scan_idle,
        scan_load,
        scan_shift_low,
        scan_shift_high,
        scan_done
    } scan_state_t;

    // front panel button indices
    localparam int BTN_START1 = 0;
    localparam int BTN_START2 = 1;
    localparam int BTN_COIN   = 2;
    localparam int BTN_RESET  = 3;

endpackage

`default_nettype wire

//--- design/front_button_debounce.sv
/* Synchronizes and debounces the four active-low front panel buttons.
   A change is accepted once the inputs stay stable for DEBOUNCE_CYCLES. */
`timescale 1ns/1ps
`default_nettype none

module front_button_debounce #(
    parameter int DEBOUNCE_CYCLES = 48000
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic [3:0]  button_n_i,
    output logic [3:0]  btn_pressed_o
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [3:0]        sync1_q;
    logic [3:0]        sync2_q;
    logic [3:0]        last_q;
    logic [3:0]        pressed_q;
    logic [CNT_W-1:0]  cnt_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            // all buttons read released
            sync1_q   <= '1;
            sync2_q   <= '1;
            last_q    <= '1;
            cnt_q     <= '0;
            pressed_q <= '0;
        end else begin
            sync1_q <= button_n_i;
            sync2_q <= sync1_q;
            last_q  <= sync2_q;
            // one counter shared by all four buttons
            if (sync2_q != last_q) begin
                cnt_q <= CNT_W'(DEBOUNCE_CYCLES - 1);
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                pressed_q <= ~last_q;
            end
        end
    end

    assign btn_pressed_o = pressed_q;

endmodule

`default_nettype wire

//--- design/joy_pkg.sv
/* Pad-side types: raw DB9 samples and decoded player words with their bit layout.
   Used by the decoder, the merge stage and the top level through scoped names. */
`default_nettype none

package joy_pkg;

    // one pad's sampled lines, active high
    typedef logic [5:0]  raw_pad_t;
    // decoded player word, active high
    typedef logic [11:0] joy_word_t;
    // player word in board output order
    typedef logic [11:0] out_word_t;

    // select half-phases per decode cycle
    localparam int SEGA_PHASES = 8;

    // raw_pad_t bit positions
    localparam int RAW_UP    = 0;
    localparam int RAW_DOWN  = 1;
    localparam int RAW_LEFT  = 2;
    localparam int RAW_RIGHT = 3;
    localparam int RAW_P6    = 4;
    localparam int RAW_P9    = 5;

    // joy_word_t bit positions
    localparam int W_UP    = 0;
    localparam int W_DOWN  = 1;
    localparam int W_LEFT  = 2;
    localparam int W_RIGHT = 3;
    localparam int W_B     = 4;
    localparam int W_C     = 5;
    localparam int W_A     = 6;
    localparam int W_START = 7;
    localparam int W_Z     = 8;
    localparam int W_Y     = 9;
    localparam int W_X     = 10;
    localparam int W_MODE  = 11;

endpackage

`default_nettype wire

//--- design/joy_serial_scan.sv
/* Drives the load/clock lines of the board shift chain and captures both pads.
   Scans continuously and strobes frame_done_o once per complete frame. */
`timescale 1ns/1ps
`default_nettype none

module joy_serial_scan #(
    parameter int CLK_DIV = 4
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                joy_data_i,
    output logic                joy_clk_o,
    output logic                joy_load_o,
    output joy_pkg::raw_pad_t   pad1_raw_o,
    output joy_pkg::raw_pad_t   pad2_raw_o,
    output logic                frame_done_o
);

    localparam int DIV_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int BIT_W  = $clog2(board_pkg::CHAIN_BITS);
    localparam int PAD_W  = $bits(joy_pkg::raw_pad_t);

    board_pkg::scan_state_t            state_q;
    logic [DIV_W-1:0]                  div_q;
    logic [BIT_W-1:0]                  bit_q;
    logic [board_pkg::CHAIN_BITS-1:0]  shift_q;
    joy_pkg::raw_pad_t                 pad1_q;
    joy_pkg::raw_pad_t                 pad2_q;
    logic                              joy_clk_q;
    logic                              joy_load_q;
    logic                              frame_done_q;
    logic                              div_end;

    // last cycle of a CLK_DIV period
    assign div_end = (div_q == DIV_W'(CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q      <= board_pkg::scan_idle;
            div_q        <= '0;
            bit_q        <= '0;
            joy_clk_q    <= 1'b0;
            joy_load_q   <= 1'b1;
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= 1'b0;
            div_q        <= div_end ? '0 : div_q + 1'b1;
            case (state_q)
                board_pkg::scan_idle: begin
                    // start the load pulse with a fresh period
                    joy_load_q <= 1'b0;
                    div_q      <= '0;
                    state_q    <= board_pkg::scan_load;
                end
                board_pkg::scan_load: begin
                    if (div_end) begin
                        joy_load_q <= 1'b1;
                        state_q    <= board_pkg::scan_shift_low;
                    end
                end
                board_pkg::scan_shift_low: begin
                    if (div_end) begin
                        joy_clk_q <= 1'b1;
                        state_q   <= board_pkg::scan_shift_high;
                    end
                end
                board_pkg::scan_shift_high: begin
                    if (div_end) begin
                        joy_clk_q <= 1'b0;
                        if (bit_q == BIT_W'(board_pkg::CHAIN_BITS - 1)) begin
                            bit_q   <= '0;
                            state_q <= board_pkg::scan_done;
                        end else begin
                            bit_q   <= bit_q + 1'b1;
                            state_q <= board_pkg::scan_shift_low;
                        end
                    end
                end
                board_pkg::scan_done: begin
                    // frame complete, go straight into the next load pulse
                    frame_done_q <= 1'b1;
                    joy_load_q   <= 1'b0;
                    div_q        <= '0;
                    state_q      <= board_pkg::scan_load;
                end
                default: begin
                    state_q <= board_pkg::scan_idle;
                end
            endcase
        end
    end

    // data is sampled just before the rising edge of joy_clk_o
    // first bit out of the chain ends up in the top bit
    always_ff @(posedge clk) begin
        if (state_q == board_pkg::scan_shift_low && div_end) begin
            shift_q <= {shift_q[board_pkg::CHAIN_BITS-2:0], ~joy_data_i};
        end
        if (state_q == board_pkg::scan_done) begin
            pad1_q <= shift_q[board_pkg::PAD1_LSB +: PAD_W];
            pad2_q <= shift_q[board_pkg::PAD2_LSB +: PAD_W];
        end
    end

    assign joy_clk_o    = joy_clk_q;
    assign joy_load_o   = joy_load_q;
    assign pad1_raw_o   = pad1_q;
    assign pad2_raw_o   = pad2_q;
    assign frame_done_o = frame_done_q;

endmodule

`default_nettype wire

//--- design/joy_word_merge.sv
/* Reorders decoded player words into board order and ORs in coin and start.
   Also turns the debounced reset button into reset_o; all outputs registered. */
`timescale 1ns/1ps
`default_nettype none

module joy_word_merge (
    input  logic                clk,
    input  logic                reset_i,
    input  joy_pkg::joy_word_t  p1_word_i,
    input  joy_pkg::joy_word_t  p2_word_i,
    input  logic [3:0]          btn_pressed_i,
    output joy_pkg::out_word_t  joy1_o,
    output joy_pkg::out_word_t  joy2_o,
    output logic                reset_o
);

    joy_pkg::out_word_t  joy1_next;
    joy_pkg::out_word_t  joy2_next;
    joy_pkg::out_word_t  joy1_q;
    joy_pkg::out_word_t  joy2_q;
    logic                reset_q;

    // board order from bit 11 down: mode, start, X, Y, Z, C, B, A, right, left, down, up
    function automatic joy_pkg::out_word_t to_board_order(
        input joy_pkg::joy_word_t w,
        input logic               coin,
        input logic               start
    );
        return {w[joy_pkg::W_MODE], w[joy_pkg::W_START], w[joy_pkg::W_X], w[joy_pkg::W_Y],
                w[joy_pkg::W_Z] | coin, w[joy_pkg::W_C] | start,
                w[joy_pkg::W_B], w[joy_pkg::W_A],
                w[joy_pkg::W_RIGHT], w[joy_pkg::W_LEFT],
                w[joy_pkg::W_DOWN], w[joy_pkg::W_UP]};
    endfunction

    // coin is common to both players
    assign joy1_next = to_board_order(p1_word_i, btn_pressed_i[board_pkg::BTN_COIN],
                                      btn_pressed_i[board_pkg::BTN_START1]);
    assign joy2_next = to_board_order(p2_word_i, btn_pressed_i[board_pkg::BTN_COIN],
                                      btn_pressed_i[board_pkg::BTN_START2]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            joy1_q  <= '0;
            joy2_q  <= '0;
            reset_q <= 1'b0;
        end else begin
            joy1_q  <= joy1_next;
            joy2_q  <= joy2_next;
            reset_q <= btn_pressed_i[board_pkg::BTN_RESET];
        end
    end

    assign joy1_o  = joy1_q;
    assign joy2_o  = joy2_q;
    assign reset_o = reset_q;

endmodule

`default_nettype wire

//--- design/jtframe_neptuno_joy.sv
/* Controller front end top level with chain scan, Sega decode, button debounce and merge.
   Parameters set here reach the scanner and the debouncer. */
`timescale 1ns/1ps
`default_nettype none

module jtframe_neptuno_joy #(
    parameter int CLK_DIV         = 4,
    parameter int DEBOUNCE_CYCLES = 48000
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                joy_data_i,
    input  logic [3:0]          button_n_i,
    output logic                joy_clk_o,
    output logic                joy_load_o,
    output logic                joy_select_o,
    output joy_pkg::out_word_t  joy1_o,
    output joy_pkg::out_word_t  joy2_o,
    output logic                reset_o
);

    joy_pkg::raw_pad_t   pad1_raw;
    joy_pkg::raw_pad_t   pad2_raw;
    logic                frame_done;
    joy_pkg::joy_word_t  p1_word;
    joy_pkg::joy_word_t  p2_word;
    logic [3:0]          btn_pressed;

    // serial chain scan as the execute step
    joy_serial_scan #(
        .CLK_DIV       (CLK_DIV)
    ) u_scan (
        .clk           (clk),
        .reset_i       (reset_i),
        .joy_data_i    (joy_data_i),
        .joy_clk_o     (joy_clk_o),
        .joy_load_o    (joy_load_o),
        .pad1_raw_o    (pad1_raw),
        .pad2_raw_o    (pad2_raw),
        .frame_done_o  (frame_done)
    );

    // Sega select sequencing as the decode step
    sega_pad_decode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .pad1_raw_i    (pad1_raw),
        .pad2_raw_i    (pad2_raw),
        .frame_done_i  (frame_done),
        .joy_select_o  (joy_select_o),
        .p1_word_o     (p1_word),
        .p2_word_o     (p2_word),
        .word_valid_o  ()
    );

    front_button_debounce #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_debounce (
        .clk           (clk),
        .reset_i       (reset_i),
        .button_n_i    (button_n_i),
        .btn_pressed_o (btn_pressed)
    );

    // board order plus coin, start and reset as the result step
    joy_word_merge u_merge (
        .clk           (clk),
        .reset_i       (reset_i),
        .p1_word_i     (p1_word),
        .p2_word_i     (p2_word),
        .btn_pressed_i (btn_pressed),
        .joy1_o        (joy1_o),
        .joy2_o        (joy2_o),
        .reset_o       (reset_o)
    );

endmodule

`default_nettype wire

//--- design/sega_pad_decode.sv
/* Sequences the Sega select line over eight half-phases and builds one word per player.
   Each phase spends two frames because the one in flight at the select change is dropped. */
`timescale 1ns/1ps
`default_nettype none

module sega_pad_decode (
    input  logic                clk,
    input  logic                reset_i,
    input  joy_pkg::raw_pad_t   pad1_raw_i,
    input  joy_pkg::raw_pad_t   pad2_raw_i,
    input  logic                frame_done_i,
    output logic                joy_select_o,
    output joy_pkg::joy_word_t  p1_word_o,
    output joy_pkg::joy_word_t  p2_word_o,
    output logic                word_valid_o
);

    logic [2:0]          phase_q;
    logic                select_q;
    logic                skip_q;
    logic [1:0]          six_q;
    logic                valid_q;
    logic                take;
    logic                last_phase;
    joy_pkg::joy_word_t  p1_acc_q;
    joy_pkg::joy_word_t  p2_acc_q;
    joy_pkg::joy_word_t  p1_next;
    joy_pkg::joy_word_t  p2_next;
    joy_pkg::joy_word_t  p1_word_q;
    joy_pkg::joy_word_t  p2_word_q;

    // folds one sample into a partial word according to the phase
    function automatic joy_pkg::joy_word_t fold_sample(
        input joy_pkg::joy_word_t acc,
        input joy_pkg::raw_pad_t  raw,
        input logic [2:0]         phase,
        input logic               six
    );
        joy_pkg::joy_word_t w;
        w = acc;
        case (phase)
            // directions, B and C while select is high
            3'd0: begin
                w[joy_pkg::W_UP]    = raw[joy_pkg::RAW_UP];
                w[joy_pkg::W_DOWN]  = raw[joy_pkg::RAW_DOWN];
                w[joy_pkg::W_LEFT]  = raw[joy_pkg::RAW_LEFT];
                w[joy_pkg::W_RIGHT] = raw[joy_pkg::RAW_RIGHT];
                w[joy_pkg::W_B]     = raw[joy_pkg::RAW_P6];
                w[joy_pkg::W_C]     = raw[joy_pkg::RAW_P9];
            end
            // A and start while select is low
            3'd1: begin
                w[joy_pkg::W_A]     = raw[joy_pkg::RAW_P6];
                w[joy_pkg::W_START] = raw[joy_pkg::RAW_P9];
            end
            // extra buttons on the direction lines of six-button pads
            3'd6: begin
                w[joy_pkg::W_Z]    = six & raw[joy_pkg::RAW_UP];
                w[joy_pkg::W_Y]    = six & raw[joy_pkg::RAW_DOWN];
                w[joy_pkg::W_X]    = six & raw[joy_pkg::RAW_LEFT];
                w[joy_pkg::W_MODE] = six & raw[joy_pkg::RAW_RIGHT];
            end
            default: begin
                w = acc;
            end
        endcase
        return w;
    endfunction

    assign take       = frame_done_i & ~skip_q;
    assign last_phase = (phase_q == 3'(joy_pkg::SEGA_PHASES - 1));
    assign p1_next    = fold_sample(p1_acc_q, pad1_raw_i, phase_q, six_q[0]);
    assign p2_next    = fold_sample(p2_acc_q, pad2_raw_i, phase_q, six_q[1]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            phase_q   <= '0;
            select_q  <= 1'b1;
            skip_q    <= 1'b1;
            six_q     <= '0;
            valid_q   <= 1'b0;
            p1_word_q <= '0;
            p2_word_q <= '0;
        end else begin
            valid_q <= 1'b0;
            if (frame_done_i && skip_q) begin
                skip_q <= 1'b0;
            end
            if (take) begin
                // up and down both low in the third low phase mark a six-button pad
                if (phase_q == 3'd5) begin
                    six_q[0] <= pad1_raw_i[joy_pkg::RAW_UP] & pad1_raw_i[joy_pkg::RAW_DOWN];
                    six_q[1] <= pad2_raw_i[joy_pkg::RAW_UP] & pad2_raw_i[joy_pkg::RAW_DOWN];
                end
                if (last_phase) begin
                    p1_word_q <= p1_next;
                    p2_word_q <= p2_next;
                    valid_q   <= 1'b1;
                end
                phase_q  <= phase_q + 1'b1;
                // select goes high for the even phase that follows an odd one
                select_q <= phase_q[0];
                skip_q   <= 1'b1;
            end
        end
    end

    // partial words built up over one decode cycle
    always_ff @(posedge clk) begin
        if (take) begin
            p1_acc_q <= p1_next;
            p2_acc_q <= p2_next;
        end
    end

    assign joy_select_o = select_q;
    assign p1_word_o    = p1_word_q;
    assign p2_word_o    = p2_word_q;
    assign word_valid_o = valid_q;

endmodule

`default_nettype wire

//--- filelist.f
design/joy_pkg.sv
design/board_pkg.sv
design/joy_serial_scan.sv
design/sega_pad_decode.sv
design/front_button_debounce.sv
design/joy_word_merge.sv
design/jtframe_neptuno_joy.sv
sim/joy_chain_model.sv
sim/tb_neptuno_joy.sv

//--- sim/joy_chain_model.sv
/* Behavioral model of the board shift chain with two Sega pads on it.
   Pads follow the select line and count its edges like real three/six-button pads. */
`timescale 1ns/1ps
`default_nettype none

module joy_chain_model (
    input  logic         clk,
    input  logic         reset_i,
    input  logic         joy_clk_i,
    input  logic         joy_load_i,
    input  logic         joy_select_i,
    input  logic [11:0]  pad1_btn_i,
    input  logic [11:0]  pad2_btn_i,
    input  logic [1:0]   six_btn_i,
    output logic         joy_data_o
);

    // pressed buttons arrive in board output order
    localparam int O_UP    = 0;
    localparam int O_DOWN  = 1;
    localparam int O_LEFT  = 2;
    localparam int O_RIGHT = 3;
    localparam int O_A     = 4;
    localparam int O_B     = 5;
    localparam int O_C     = 6;
    localparam int O_Z     = 7;
    localparam int O_Y     = 8;
    localparam int O_X     = 9;
    localparam int O_START = 10;
    localparam int O_MODE  = 11;

    logic [15:0]  chain_q;
    logic [2:0]   edge_cnt_q;
    logic         sel_q;

    // DB9 lines a pad pulls low in the order {p9, p6, right, left, down, up}
    function automatic joy_pkg::raw_pad_t pad_lines(
        input logic [11:0] btn,
        input logic        six,
        input logic        sel,
        input logic [2:0]  cnt
    );
        if (sel && six && cnt == 3'd6) begin
            // extra buttons on the direction lines in the fourth high half
            return {btn[O_C], btn[O_B], btn[O_MODE], btn[O_X], btn[O_Y], btn[O_Z]};
        end else if (sel) begin
            return {btn[O_C], btn[O_B], btn[O_RIGHT], btn[O_LEFT], btn[O_DOWN], btn[O_UP]};
        end else if (six && cnt == 3'd5) begin
            // all four directions low in the third low half identify a six-button pad
            return {btn[O_START], btn[O_A], 4'b1111};
        end else if (six && cnt == 3'd7) begin
            return {btn[O_START], btn[O_A], 4'b0000};
        end
        // left and right are grounded while select is low
        return {btn[O_START], btn[O_A], 2'b11, btn[O_DOWN], btn[O_UP]};
    endfunction

    // select edge counter that wraps every eight half-phases
    always @(posedge clk) begin
        if (reset_i) begin
            edge_cnt_q <= '0;
            sel_q      <= 1'b1;
        end else if (joy_select_i != sel_q) begin
            sel_q      <= joy_select_i;
            edge_cnt_q <= edge_cnt_q + 1'b1;
        end
    end

    // parallel load on the falling load edge and shift on each chain clock
    always @(negedge joy_load_i or posedge joy_clk_i) begin
        if (!joy_load_i) begin
            chain_q <= {2'b00, pad_lines(pad2_btn_i, six_btn_i[1], joy_select_i, edge_cnt_q),
                        2'b00, pad_lines(pad1_btn_i, six_btn_i[0], joy_select_i, edge_cnt_q)};
        end else begin
            chain_q <= {chain_q[14:0], 1'b0};
        end
    end

    // top bit leaves the chain first on an active-low line
    assign joy_data_o = ~chain_q[15];

endmodule

`default_nettype wire

//--- sim/tb_neptuno_joy.sv
/* Directed testbench for the controller front end with a chain and pad model.
   Checks player words, coin/start merging and the debounced reset request. */
`timescale 1ns/1ps
`default_nettype none

module tb_neptuno_joy;

    localparam int CLK_DIV         = 2;
    localparam int DEBOUNCE_CYCLES = 16;
    // pad settings and button tests that each get 40 frames
    localparam int NUM_STEPS       = 25;
    localparam int FRAME_CYCLES    = board_pkg::CHAIN_BITS * 2 * CLK_DIV + 8;
    localparam int TIMEOUT_NS      = NUM_STEPS * 40 * FRAME_CYCLES * 10;
    // a three-button pad sets everything except mode, X, Y and Z
    localparam logic [11:0] THREE_BUTTON_MASK = 12'h47F;
    localparam logic [11:0] COIN_BIT          = 12'h080;
    localparam logic [11:0] START_BIT         = 12'h040;

    logic         clk;
    logic         reset;
    logic [3:0]   button_n;
    logic         joy_data;
    logic         joy_clk;
    logic         joy_load;
    logic         joy_select;
    logic [11:0]  joy1;
    logic [11:0]  joy2;
    logic         reset_req;
    // pressed pad buttons in board order and six-button flags
    logic [11:0]  pad1_btn;
    logic [11:0]  pad2_btn;
    logic [1:0]   six_btn;
    int           seed;

    jtframe_neptuno_joy #(
        .CLK_DIV         (CLK_DIV),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) dut (
        .clk          (clk),
        .reset_i      (reset),
        .joy_data_i   (joy_data),
        .button_n_i   (button_n),
        .joy_clk_o    (joy_clk),
        .joy_load_o   (joy_load),
        .joy_select_o (joy_select),
        .joy1_o       (joy1),
        .joy2_o       (joy2),
        .reset_o      (reset_req)
    );

    joy_chain_model chain (
        .clk          (clk),
        .reset_i      (reset),
        .joy_clk_i    (joy_clk),
        .joy_load_i   (joy_load),
        .joy_select_i (joy_select),
        .pad1_btn_i   (pad1_btn),
        .pad2_btn_i   (pad2_btn),
        .six_btn_i    (six_btn),
        .joy_data_o   (joy_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT did not finish the tests in time");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check_value(input string name, input logic [11:0] expected,
                               input logic [11:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "check %s failed", name);
        end
    endtask

    // 16 toggles always span one full decode cycle after the pad change
    task automatic wait_select_toggles(input int count);
        int   seen;
        logic last;
        seen = 0;
        last = joy_select;
        while (seen < count) begin
            next_cycle();
            if (joy_select !== last) begin
                seen++;
                last = joy_select;
            end
        end
        // merge output register
        wait_cycles(2);
    endtask

    task automatic set_pads(input logic [11:0] p1, input logic [11:0] p2,
                            input logic [1:0] six);
        pad1_btn = p1;
        pad2_btn = p2;
        six_btn  = six;
        wait_select_toggles(16);
    endtask

    task automatic reset_values();
        reset = 1'b1;
        wait_cycles(10);
        check_value("reset joy1", 12'h000, joy1);
        check_value("reset joy2", 12'h000, joy2);
        check_value("reset reset_o", 12'h000, {11'd0, reset_req});
        check_value("reset joy_load", 12'h001, {11'd0, joy_load});
        check_value("reset joy_clk", 12'h000, {11'd0, joy_clk});
        check_value("reset joy_select", 12'h001, {11'd0, joy_select});
        reset = 1'b0;
    endtask

    task automatic three_button_words();
        // up, left, A and C plus X and Z that a three-button pad cannot report
        logic [11:0] set_a;
        // down, right, B, start with Y and mode held
        logic [11:0] set_b;
        set_a = 12'h2D5;
        set_b = 12'hD2A;
        set_pads(set_a, set_b, 2'b00);
        check_value("three_button p1 a", set_a & THREE_BUTTON_MASK, joy1);
        check_value("three_button p2 b", set_b & THREE_BUTTON_MASK, joy2);
        set_pads(set_b, set_a, 2'b00);
        check_value("three_button p1 b", set_b & THREE_BUTTON_MASK, joy1);
        check_value("three_button p2 a", set_a & THREE_BUTTON_MASK, joy2);
    endtask

    task automatic six_button_words();
        logic [31:0] r1;
        logic [31:0] r2;
        for (int i = 0; i < 20; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            set_pads(r1[11:0], r2[11:0], 2'b11);
            // six-button pads report every bit in place
            check_value($sformatf("six_button p1 set %0d", i), r1[11:0], joy1);
            check_value($sformatf("six_button p2 set %0d", i), r2[11:0], joy2);
        end
    endtask

    task automatic hold_button(input int idx, input int cycles);
        button_n[idx] = 1'b0;
        wait_cycles(cycles);
    endtask

    task automatic release_button(input int idx);
        button_n[idx] = 1'b1;
        wait_cycles(40);
    endtask

    task automatic coin_and_start();
        set_pads(12'h000, 12'h000, 2'b00);
        hold_button(board_pkg::BTN_COIN, 40);
        check_value("coin joy1", COIN_BIT, joy1);
        check_value("coin joy2", COIN_BIT, joy2);
        release_button(board_pkg::BTN_COIN);
        hold_button(board_pkg::BTN_START1, 40);
        check_value("start1 joy1", START_BIT, joy1);
        check_value("start1 joy2", 12'h000, joy2);
        release_button(board_pkg::BTN_START1);
        hold_button(board_pkg::BTN_START2, 40);
        check_value("start2 joy1", 12'h000, joy1);
        check_value("start2 joy2", START_BIT, joy2);
        release_button(board_pkg::BTN_START2);
        check_value("buttons released joy2", 12'h000, joy2);
    endtask

    task automatic reset_button_filter();
        // a short glitch must never reach reset_o
        hold_button(board_pkg::BTN_RESET, 8);
        button_n[board_pkg::BTN_RESET] = 1'b1;
        for (int i = 0; i < 60; i++) begin
            next_cycle();
            check_value("reset glitch", 12'h000, {11'd0, reset_req});
        end
        hold_button(board_pkg::BTN_RESET, 40);
        check_value("reset held", 12'h001, {11'd0, reset_req});
        release_button(board_pkg::BTN_RESET);
        check_value("reset released", 12'h000, {11'd0, reset_req});
    endtask

    initial begin
        seed     = 32'h0ae7_461f;
        reset    = 1'b1;
        button_n = 4'hF;
        pad1_btn = 12'h000;
        pad2_btn = 12'h000;
        six_btn  = 2'b00;
        reset_values();
        three_button_words();
        six_button_words();
        coin_and_start();
        reset_button_filter();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
